// File: files.f
hw/cal_pkg.sv
hw/lin_scale.sv
hw/cal_regs.sv
hw/stream_rr_arb.sv
hw/dual_cal_top.sv
tb/dual_cal_props.sv
tb/dual_cal_tb.sv

// File: tb/dual_cal_tb.sv
`timescale 1ns/1ps

module dual_cal_tb import cal_pkg::*;;

  localparam int pkt_n     = 6;                  // packets per channel per phase
  localparam int max_words = 4 * 2 * pkt_n * 8;  // four phases, worst case lengths

  logic        sti;
  logic        rst;
  smp_a_t      a_data;
  logic        a_last;
  logic        a_valid;
  logic        a_ready;
  smp_b_t      b_data;
  logic        b_last;
  logic        b_valid;
  logic        b_ready;
  logic        cfg_we;
  logic [1:0]  cfg_addr;
  logic [15:0] cfg_wdata;
  smp_out_t    out_data;
  logic        out_chan;
  logic        out_last;
  logic        out_valid;
  logic        out_ready;

  logic [31:0] rng_state[3];  // channel a, channel b, sink
  logic [16:0] exp_a[$];  // {last, value}
  logic [16:0] exp_b[$];
  int    cur_mul[2];  // model of the register file
  int    cur_sum[2];
  int    val_err   = 0;
  int    other_err = 0;
  int    hi_hits   = 0;
  int    lo_hits   = 0;
  int    switches  = 0;
  bit    rdy_rand  = 1'b0;
  string test_name = "reset";

  dual_cal_top dut0 (.*);

  initial begin
    sti = 1'b0;
    forever #10 sti = ~sti;
  end

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift_next(input int k);
    logic [31:0] s;
    s = rng_state[k];
    s ^= s << 13;
    s ^= s >> 17;
    s ^= s << 5;
    rng_state[k] = s;
    return s;
  endfunction

  // gain, floor shift, offset, clamp to the out_w rails
  function automatic smp_out_t calib(input int x, input int g, input int o);
    longint s;
    longint top;
    top = (longint'(1) <<< (out_w - 1)) - 1;
    s = (longint'(x) * g) >>> (mul_w - 2);
    s = s + o;
    if (s > top) s = top;
    else if (s < -top - 1) s = -top - 1;
    return s[out_w-1:0];
  endfunction

  task automatic drive(input bit ch, input logic v, input logic [15:0] d, input logic l);
    if (ch) begin
      b_valid = v;
      b_data  = d[11:0];
      b_last  = l;
    end else begin
      a_valid = v;
      a_data  = d[13:0];
      a_last  = l;
    end
  endtask

  task automatic send_packets(input bit ch);
    int          len;
    int          xs;
    logic [31:0] x;
    smp_out_t    ev;
    for (int p = 0; p < pkt_n; p++) begin
      len = xorshift_next(ch) % 8 + 1;
      for (int i = 0; i < len; i++) begin
        while (xorshift_next(ch) % 4 == 0) begin  // valid gap
          drive(ch, 1'b0, 16'h0, 1'b0);
          @(negedge sti);
        end
        x = xorshift_next(ch);
        drive(ch, 1'b1, x[15:0], i == len - 1);
        do begin
          @(posedge sti);
        end while (!(ch ? b_ready : a_ready));
        xs = ch ? int'($signed(x[11:0])) : int'($signed(x[13:0]));
        ev = calib(xs, cur_mul[ch], cur_sum[ch]);
        if (ev == 32767) hi_hits++;
        if (ev == -32768) lo_hits++;
        if (ch) exp_b.push_back({i == len - 1, ev});
        else exp_a.push_back({i == len - 1, ev});
        @(negedge sti);
      end
    end
    drive(ch, 1'b0, 16'h0, 1'b0);
  endtask

  task automatic write_cfg(input logic [1:0] addr, input int v);
    @(negedge sti);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = v[15:0];
    @(negedge sti);
    cfg_we = 1'b0;
  endtask

  // only called with both channels drained
  task automatic set_cal(input int ga, input int oa, input int gb, input int ob);
    write_cfg(addr_mul_a, ga);
    write_cfg(addr_sum_a, oa);
    write_cfg(addr_mul_b, gb);
    write_cfg(addr_sum_b, ob);
    cur_mul = '{ga, gb};
    cur_sum = '{oa, ob};
  endtask

  task automatic run_phase(input string name, input bit rr);
    int n;
    test_name = name;
    rdy_rand  = rr;
    n = 0;
    fork
      send_packets(1'b0);
      send_packets(1'b1);
    join
    while (exp_a.size() + exp_b.size() != 0 && n < 400) begin
      @(posedge sti);
      n++;
    end
    assert (exp_a.size() + exp_b.size() == 0) else begin
      $display("%s: %0d words of a and %0d of b never came out", name, exp_a.size(),
               exp_b.size());
      other_err++;
    end
    exp_a.delete();
    exp_b.delete();
    repeat (4) @(negedge sti);
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin : main
    rst = 1'b1;
    drive(1'b0, 1'b0, 16'h0, 1'b0);
    drive(1'b1, 1'b0, 16'h0, 1'b0);
    {cfg_we, cfg_addr, cfg_wdata, out_ready} = '0;
    rng_state[2] = 32'd8;  // seed
    // channel streams branch off the seed
    rng_state[0] = xorshift_next(2);
    rng_state[1] = xorshift_next(2);
    cur_mul = '{16384, 16384};  // unity gain, 2**14
    cur_sum = '{0, 0};
    repeat (5) @(negedge sti);
    rst = 1'b0;
    run_phase("default", 1'b0);
    set_cal(-12345, 100, 5000, -77);  // negative gain floors downward
    run_phase("programmed", 1'b1);
    set_cal(32767, 20000, -32768, -31000);  // a hits the top rail, b the bottom
    run_phase("saturate", 1'b0);
    assert (hi_hits > 0 && lo_hits > 0) else begin
      $display("saturate: rails not reached, top %0d bottom %0d", hi_hits, lo_hits);
      other_err++;
    end
    set_cal(20000, -300, -9000, 1234);
    switches = 0;
    run_phase("backpressure", 1'b1);
    assert (switches > 1) else begin
      $display("backpressure: channels did not take turns on the output");
      other_err++;
    end
    $display("errors: value %0d, other %0d, assertion %0d", val_err, other_err,
             dut0.props0.fails);
    if (val_err + other_err + dut0.props0.fails == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  initial begin : sink_ready
    forever begin
      @(negedge sti);
      if (!rst) out_ready = rdy_rand ? (xorshift_next(2) % 3 != 0) : 1'b1;
    end
  end

  ////////////////////////////////////////
  // compare
  ////////////////////////////////////////

  initial begin : compare
    logic [16:0] e;
    bit          in_pkt;
    logic        pkt_chan;
    in_pkt   = 1'b0;
    pkt_chan = 1'b0;
    forever begin
      @(posedge sti);  // dut state still pre-edge here
      if (!rst && out_valid && out_ready) begin
        assert (!in_pkt || out_chan == pkt_chan) else begin
          $display("%s: packet of channel %0d split by channel %0d", test_name, pkt_chan,
                   out_chan);
          other_err++;
        end
        if (!in_pkt && out_chan != pkt_chan) switches++;
        pkt_chan = out_chan;
        in_pkt   = !out_last;
        assert ((out_chan ? exp_b.size() : exp_a.size()) != 0) else begin
          $display("%s: word on channel %0d with none expected", test_name, out_chan);
          other_err++;
        end
        if ((out_chan ? exp_b.size() : exp_a.size()) != 0) begin
          e = out_chan ? exp_b.pop_front() : exp_a.pop_front();
          assert (out_data === e[15:0] && out_last === e[16]) else begin
            $display("** Error %s: chan %0d expected %0d last %0b, actual %0d last %0b",
                     test_name, out_chan, $signed(e[15:0]), e[16], out_data, out_last);
            val_err++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (max_words * 40 + 400) @(posedge sti);
    $display("timeout: run did not finish in the expected number of cycles");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

// File: tb/dual_cal_props.sv
`timescale 1ns/1ps

// output stream rules, bound into dual_cal_top
module dual_cal_props import cal_pkg::*; (
  input logic     sti,
  input logic     rst,
  input smp_out_t out_data,
  input logic     out_chan,
  input logic     out_last,
  input logic     out_valid,
  input logic     out_ready
);

  int   fails;     // read by the testbench
  logic pkt_open;  // a word without last has gone out
  logic pkt_chan;

  initial fails = 0;

  always_ff @(posedge sti) begin
    if (rst) begin
      pkt_open <= 1'b0;
    end else if (out_valid && out_ready) begin
      pkt_open <= ~out_last;
      pkt_chan <= out_chan;  // owner of the open packet
    end
  end

  ////////////////////////////////////////
  // properties
  ////////////////////////////////////////

  idle_after_rst: assert property (@(posedge sti) rst |=> !out_valid)
    else begin
      $error("out_valid high right after reset");
      fails++;
    end

  hold_on_stall: assert property (@(posedge sti) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_chan)
      && $stable(out_last))
    else begin
      $error("output word changed while stalled");
      fails++;
    end

  chan_in_pkt: assert property (@(posedge sti) disable iff (rst)
    out_valid && pkt_open |-> out_chan == pkt_chan)
    else begin
      $error("channel tag changed inside a packet");
      fails++;
    end

endmodule

bind dual_cal_top dual_cal_props props0 (
  .sti       (sti),
  .rst       (rst),
  .out_data  (out_data),
  .out_chan  (out_chan),
  .out_last  (out_last),
  .out_valid (out_valid),
  .out_ready (out_ready)
);

// File: hw/dual_cal_top.sv
`timescale 1ns/1ps

// two calibrated channels merged onto one tagged stream
module dual_cal_top import cal_pkg::*; (
  input  logic        sti,
  input  logic        rst,
  // channel a input
  input  smp_a_t      a_data,
  input  logic        a_last,
  input  logic        a_valid,
  output logic        a_ready,
  // channel b input
  input  smp_b_t      b_data,
  input  logic        b_last,
  input  logic        b_valid,
  output logic        b_ready,
  // register writes
  input  logic        cfg_we,
  input  logic [1:0]  cfg_addr,
  input  logic [15:0] cfg_wdata,
  // merged output
  output smp_out_t    out_data,
  output logic        out_chan,
  output logic        out_last,
  output logic        out_valid,
  input  logic        out_ready
);

  ////////////////////////////////////////
  // local signals
  ////////////////////////////////////////

  logic signed [mul_w-1:0] mul_a;
  logic signed [sum_w-1:0] sum_a;
  logic signed [mul_w-1:0] mul_b;
  logic signed [sum_w-1:0] sum_b;

  // calibrated streams into the arbiter
  smp_out_t ca_data;
  logic     ca_last;
  logic     ca_valid;
  logic     ca_ready;
  smp_out_t cb_data;
  logic     cb_last;
  logic     cb_valid;
  logic     cb_ready;

  ////////////////////////////////////////
  // calibration registers
  ////////////////////////////////////////

  cal_regs regs0 (
    .sti       (sti),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .mul_a     (mul_a),
    .sum_a     (sum_a),
    .mul_b     (mul_b),
    .sum_b     (sum_b)
  );

  ////////////////////////////////////////
  // per channel scaling
  ////////////////////////////////////////

  lin_scale #(.din_t (smp_a_t)) scale_a (  // 14-bit channel
    .sti       (sti),
    .rst       (rst),
    .in_data   (a_data),
    .in_last   (a_last),
    .in_valid  (a_valid),
    .in_ready  (a_ready),
    .mul       (mul_a),
    .sum       (sum_a),
    .out_data  (ca_data),
    .out_last  (ca_last),
    .out_valid (ca_valid),
    .out_ready (ca_ready)
  );

  lin_scale #(.din_t (smp_b_t)) scale_b (  // 12-bit channel
    .sti       (sti),
    .rst       (rst),
    .in_data   (b_data),
    .in_last   (b_last),
    .in_valid  (b_valid),
    .in_ready  (b_ready),
    .mul       (mul_b),
    .sum       (sum_b),
    .out_data  (cb_data),
    .out_last  (cb_last),
    .out_valid (cb_valid),
    .out_ready (cb_ready)
  );

  ////////////////////////////////////////
  // merge
  ////////////////////////////////////////

  stream_rr_arb arb0 (
    .sti       (sti),
    .rst       (rst),
    .a_data    (ca_data),
    .a_last    (ca_last),
    .a_valid   (ca_valid),
    .a_ready   (ca_ready),
    .b_data    (cb_data),
    .b_last    (cb_last),
    .b_valid   (cb_valid),
    .b_ready   (cb_ready),
    .out_data  (out_data),
    .out_chan  (out_chan),
    .out_last  (out_last),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

// File: hw/stream_rr_arb.sv
`timescale 1ns/1ps

// two streams onto one, whole packets, round robin
module stream_rr_arb import cal_pkg::*; (
  input  logic     sti,
  input  logic     rst,
  // channel a
  input  smp_out_t a_data,
  input  logic     a_last,
  input  logic     a_valid,
  output logic     a_ready,
  // channel b
  input  smp_out_t b_data,
  input  logic     b_last,
  input  logic     b_valid,
  output logic     b_ready,
  // merged stream
  output smp_out_t out_data,
  output logic     out_chan,  // 0 a, 1 b
  output logic     out_last,
  output logic     out_valid,
  input  logic     out_ready
);

  ////////////////////////////////////////
  // local signals
  ////////////////////////////////////////

  logic gnt;       // owner, 0 a, 1 b
  logic busy;      // packet open on gnt
  logic sel;       // channel served this cycle
  logic sel_vld;   // valid of sel
  logic oth_vld;   // valid of the channel not selected
  logic sel_last;
  logic take;      // output register can load
  logic acc;       // word accepted from sel

  ////////////////////////////////////////
  // selection
  ////////////////////////////////////////

  always_comb begin
    if (busy) begin
      sel = gnt;  // never split a packet
    end else if (gnt) begin
      sel = b_valid | ~a_valid;  // idle owner yields
    end else begin
      sel = b_valid & ~a_valid;
    end
  end

  assign sel_vld  = sel ? b_valid : a_valid;
  assign oth_vld  = sel ? a_valid : b_valid;
  assign sel_last = sel ? b_last : a_last;

  assign take    = out_ready | ~out_valid;
  assign a_ready = take & ~sel;
  assign b_ready = take & sel;
  assign acc     = take & sel_vld;

  ////////////////////////////////////////
  // grant
  ////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (rst) begin
      gnt  <= 1'b0;
      busy <= 1'b0;
    end else if (acc) begin
      if (sel_last) begin
        busy <= 1'b0;
        gnt  <= oth_vld ? ~sel : sel;  // other side first if waiting
      end else begin
        busy <= 1'b1;
        gnt  <= sel;
      end
    end
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (take) begin
      out_valid <= sel_vld;
    end
  end

  always_ff @(posedge sti) begin
    if (acc) begin
      out_data <= sel ? b_data : a_data;
      out_chan <= sel;       // tag travels with the word
      out_last <= sel_last;
    end
  end

endmodule

// File: hw/cal_regs.sv
`timescale 1ns/1ps

// gain and offset for both channels, write only
module cal_regs import cal_pkg::*; (
  input  logic                    sti,
  input  logic                    rst,
  // write port
  input  logic                    cfg_we,
  input  logic [1:0]              cfg_addr,
  input  logic [15:0]             cfg_wdata,
  // calibration words
  output logic signed [mul_w-1:0] mul_a,
  output logic signed [sum_w-1:0] sum_a,
  output logic signed [mul_w-1:0] mul_b,
  output logic signed [sum_w-1:0] sum_b
);

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  logic wr_mul_a;
  logic wr_sum_a;
  logic wr_mul_b;
  logic wr_sum_b;

  always_comb begin
    wr_mul_a = 1'b0;
    wr_sum_a = 1'b0;
    wr_mul_b = 1'b0;
    wr_sum_b = 1'b0;
    if (cfg_we) begin
      case (cfg_addr)  // full 2-bit map
        addr_mul_a: wr_mul_a = 1'b1;
        addr_sum_a: wr_sum_a = 1'b1;
        addr_mul_b: wr_mul_b = 1'b1;
        addr_sum_b: wr_sum_b = 1'b1;
      endcase
    end
  end

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  // reset gives a pass-through calibration
  always_ff @(posedge sti) begin
    if (rst) begin
      mul_a <= gain_unity;
      sum_a <= '0;
      mul_b <= gain_unity;
      sum_b <= '0;
    end else begin
      if (wr_mul_a) begin
        mul_a <= cfg_wdata;
      end
      if (wr_sum_a) begin
        sum_a <= cfg_wdata;
      end
      if (wr_mul_b) begin
        mul_b <= cfg_wdata;
      end
      if (wr_sum_b) begin
        sum_b <= cfg_wdata;
      end
    end
  end

endmodule

// File: hw/lin_scale.sv
`timescale 1ns/1ps

// out = sat((x * mul) >>> (mul_w-2) + sum), three register stages
module lin_scale import cal_pkg::*; #(
  parameter type din_t = smp_a_t  // signed input sample of any width
) (
  input  logic                    sti,
  input  logic                    rst,
  // input stream
  input  din_t                    in_data,
  input  logic                    in_last,
  input  logic                    in_valid,
  output logic                    in_ready,
  // calibration words
  input  logic signed [mul_w-1:0] mul,
  input  logic signed [sum_w-1:0] sum,
  // output stream
  output smp_out_t                out_data,
  output logic                    out_last,
  output logic                    out_valid,
  input  logic                    out_ready
);

  ////////////////////////////////////////
  // local signals
  ////////////////////////////////////////

  logic live;  // low in reset, keeps in_ready down

  // multiply stage
  logic signed [$bits(din_t)+mul_w-1:0] mul_q;
  logic                                 mul_last;
  logic                                 mul_vld;
  logic                                 mul_ld;

  // shifted product, no register
  logic signed [$bits(din_t)+mul_w-1:0] shf;

  // offset stage, one guard bit over the product
  logic signed [$bits(din_t)+mul_w:0]   sum_q;
  logic                                 sum_last;
  logic                                 sum_vld;
  logic                                 sum_ld;

  // saturation stage
  logic                                 sat_ld;
  logic                                 sat_ok;  // sum fits in out_w bits

  ////////////////////////////////////////
  // handshake chain
  ////////////////////////////////////////

  // a stage loads when empty or when its word leaves
  assign sat_ld   = out_ready | ~out_valid;
  assign sum_ld   = sat_ld | ~sum_vld;
  assign mul_ld   = sum_ld | ~mul_vld;
  assign in_ready = mul_ld & live;

  always_ff @(posedge sti) begin
    if (rst) begin
      live <= 1'b0;
    end else begin
      live <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // multiply
  ////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (rst) begin
      mul_vld <= 1'b0;
    end else if (mul_ld) begin
      mul_vld <= in_valid & live;
    end
  end

  always_ff @(posedge sti) begin
    if (in_valid && in_ready) begin
      mul_q    <= in_data * mul;  // full signed product
      mul_last <= in_last;
    end
  end

  ////////////////////////////////////////
  // shift and offset
  ////////////////////////////////////////

  // arithmetic shift, rounds toward minus infinity
  assign shf = mul_q >>> (mul_w - 2);

  always_ff @(posedge sti) begin
    if (rst) begin
      sum_vld <= 1'b0;
    end else if (sum_ld) begin
      sum_vld <= mul_vld;
    end
  end

  always_ff @(posedge sti) begin
    if (mul_vld && sum_ld) begin
      sum_q    <= shf + sum;  // no overflow with guard bit
      sum_last <= mul_last;
    end
  end

  ////////////////////////////////////////
  // saturation
  ////////////////////////////////////////

  // in range when every bit above the out_w sign matches it
  assign sat_ok = (&sum_q[$bits(din_t)+mul_w:out_w-1])
                | ~(|sum_q[$bits(din_t)+mul_w:out_w-1]);

  always_ff @(posedge sti) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (sat_ld) begin
      out_valid <= sum_vld;
    end
  end

  always_ff @(posedge sti) begin
    if (sum_vld && sat_ld) begin
      if (sat_ok) begin
        out_data <= sum_q[out_w-1:0];
      end else begin
        // rail picked by the true sign
        out_data <= {sum_q[$bits(din_t)+mul_w], {(out_w-1){~sum_q[$bits(din_t)+mul_w]}}};
      end
      out_last <= sum_last;
    end
  end

endmodule

// File: hw/cal_pkg.sv
package cal_pkg;

  ////////////////////////////////////////
  // widths
  ////////////////////////////////////////

  localparam int mul_w = 16;  // gain, signed, unity at 2**(mul_w-2)
  localparam int sum_w = 16;  // offset, signed
  localparam int out_w = 16;  // calibrated sample

  ////////////////////////////////////////
  // sample types
  ////////////////////////////////////////

  typedef logic signed [13:0]      smp_a_t;    // channel a adc word
  typedef logic signed [11:0]      smp_b_t;    // channel b adc word
  typedef logic signed [out_w-1:0] smp_out_t;  // after calibration

  // product is shifted by mul_w-2, so this is a gain of 1.0
  localparam logic signed [mul_w-1:0] gain_unity = 16'sd16384;

  ////////////////////////////////////////
  // register map
  ////////////////////////////////////////

  // all four codes in use
  localparam logic [1:0] addr_mul_a = 2'd0;
  localparam logic [1:0] addr_sum_a = 2'd1;
  localparam logic [1:0] addr_mul_b = 2'd2;
  localparam logic [1:0] addr_sum_b = 2'd3;

endpackage
